//--- logic/csr_pkg.sv
// widths, typedefs, csr addresses, access operations and counter event indices
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // widths and types
  ////////////////////////////////////////////////////////////

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  // top bit marks an interrupt, low 5 bits the code
  typedef logic [5:0]  exc_cause_t;

  localparam int N_PERF_CNT = 8;
  // one bit per counter
  typedef logic [N_PERF_CNT-1:0] perf_mask_t;

  // access operation from decode
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////////////////////////
  // addresses
  ////////////////////////////////////////////////////////////

  localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
  localparam csr_addr_t ADDR_MISA      = 12'h301;
  localparam csr_addr_t ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t ADDR_MEPC      = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
  localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
  localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
  localparam csr_addr_t ADDR_MHARTID   = 12'hF14;
  // perf counter block
  localparam csr_addr_t ADDR_PCER      = 12'h7A0;
  localparam csr_addr_t ADDR_PCMR      = 12'h7A1;
  localparam csr_addr_t ADDR_PCCR_BASE = 12'h780;
  localparam csr_addr_t ADDR_PCCR_ALL  = 12'h79F;

  // mstatus fields, mpp is two bits wide
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;

  // counter event slots
  localparam int EV_CYCLE    = 0;
  localparam int EV_INSTR    = 1;
  localparam int EV_LD_STALL = 2;
  localparam int EV_IMISS    = 3;
  localparam int EV_LOAD     = 4;
  localparam int EV_STORE    = 5;
  localparam int EV_BRANCH   = 6;
  localparam int EV_BR_TAKEN = 7;

  // bit 0 global enable, bit 1 saturate
  localparam logic [1:0] PCMR_RESET = 2'd3;

endpackage

`default_nettype wire

//--- logic/csr_access_if.sv
// interface for the decoded csr access between controller and register blocks
`timescale 1ns/10ps
`default_nettype none

interface csr_access_if
  import csr_pkg::*;
();

  // access side, driven by the controller
  csr_addr_t addr;
  // final value with set or clear already applied
  csr_data_t wdata;
  logic      we;

  // read side, one pair per register block
  csr_data_t rdata_trap;
  logic      hit_trap;
  csr_data_t rdata_perf;
  logic      hit_perf;

  modport ctrl (
    output addr, wdata, we,
    input  rdata_trap, hit_trap, rdata_perf, hit_perf
  );

  modport reg_blk (
    input  addr, wdata, we,
    output rdata_trap, hit_trap, rdata_perf, hit_perf
  );

endinterface

`default_nettype wire

//--- logic/csr_access_ctrl.sv
// csr access controller: operation merge, write enable and read data select
`timescale 1ns/10ps
`default_nettype none

module csr_access_ctrl
  import csr_pkg::*;
(
  input  wire logic      csr_access_i,
  input  wire csr_addr_t csr_addr_i,
  input  wire csr_op_e   csr_op_i,
  input  wire csr_data_t csr_wdata_i,
  csr_access_if.ctrl     acc,
  output csr_data_t      csr_rdata_o
);

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  // blocks decode their own addresses
  // perf block first, trap block already returns 0 when unmapped
  always_comb begin
    if (acc.hit_perf) begin
      csr_rdata_o = acc.rdata_perf;
    end else if (acc.hit_trap) begin
      csr_rdata_o = acc.rdata_trap;
    end else begin
      csr_rdata_o = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  assign acc.addr = csr_addr_i;

  // set and clear act on the current read value
  always_comb begin
    case (csr_op_i)
      CSR_OP_SET:   acc.wdata = csr_rdata_o | csr_wdata_i;
      CSR_OP_CLEAR: acc.wdata = csr_rdata_o & ~csr_wdata_i;
      default:      acc.wdata = csr_wdata_i;
    endcase
  end

  // no write on a plain read or an idle cycle
  assign acc.we = csr_access_i && (csr_op_i != CSR_OP_NONE);

endmodule

`default_nettype wire

//--- logic/csr_trap_regs.sv
// machine trap registers: mstatus, mepc, mcause, identity reads, trap entry and mret
`timescale 1ns/10ps
`default_nettype none

module csr_trap_regs
  import csr_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  csr_access_if.reg_blk    acc,
  input  wire logic [3:0]  core_id_i,
  input  wire logic [5:0]  cluster_id_i,
  input  wire logic [23:0] boot_addr_i,
  input  wire csr_data_t   pc_if_i,
  input  wire csr_data_t   pc_id_i,
  input  wire csr_data_t   pc_ex_i,
  input  wire csr_data_t   branch_target_i,
  input  wire logic        exc_save_if_i,
  input  wire logic        exc_save_id_i,
  input  wire logic        exc_save_takenbranch_i,
  input  wire logic        data_load_event_ex_i,
  input  wire logic        save_exc_cause_i,
  input  wire exc_cause_t  exc_cause_i,
  input  wire logic        exc_restore_mret_i,
  output csr_data_t        epc_o,
  output logic             irq_enable_o
);

  logic       mie_q, mie_n;
  logic       mpie_q, mpie_n;
  csr_data_t  mepc_q, mepc_n;
  exc_cause_t mcause_q, mcause_n;
  csr_data_t  exc_pc;

  ////////////////////////////////////////////////////////////
  // read decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    acc.rdata_trap = '0;
    acc.hit_trap   = 1'b1;
    case (acc.addr)
      ADDR_MSTATUS: begin
        // always machine mode, mpp fixed
        acc.rdata_trap[MSTATUS_MPP_LSB +: 2] = 2'b11;
        acc.rdata_trap[MSTATUS_MPIE_BIT]     = mpie_q;
        acc.rdata_trap[MSTATUS_MIE_BIT]      = mie_q;
      end
      ADDR_MTVEC:   acc.rdata_trap = {boot_addr_i, 8'h00};
      ADDR_MEPC:    acc.rdata_trap = mepc_q;
      // interrupt flag moves up to bit 31
      ADDR_MCAUSE:  acc.rdata_trap = {mcause_q[5], 26'b0, mcause_q[4:0]};
      ADDR_MHARTID: acc.rdata_trap = {21'b0, cluster_id_i, 1'b0, core_id_i};
      // no ids allocated, read as zero
      ADDR_MISA, ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID: acc.rdata_trap = '0;
      default:      acc.hit_trap = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  // load events in ex take priority over the one-hot selects
  always_comb begin
    exc_pc = pc_id_i;
    if (data_load_event_ex_i) begin
      exc_pc = pc_ex_i;
    end else if (exc_save_if_i) begin
      exc_pc = pc_if_i;
    end else if (exc_save_takenbranch_i) begin
      exc_pc = branch_target_i;
    end
  end

  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;
    if (acc.we) begin
      case (acc.addr)
        ADDR_MSTATUS: begin
          mie_n  = acc.wdata[MSTATUS_MIE_BIT];
          mpie_n = acc.wdata[MSTATUS_MPIE_BIT];
        end
        ADDR_MEPC:   mepc_n   = acc.wdata;
        ADDR_MCAUSE: mcause_n = {acc.wdata[31], acc.wdata[4:0]};
        default: ;
      endcase
    end
    // trap entry overrides a csr write in the same cycle
    if (save_exc_cause_i) begin
      mpie_n   = mie_q;
      mie_n    = 1'b0;
      mepc_n   = exc_pc;
      mcause_n = exc_cause_i;
    end else if (exc_restore_mret_i) begin
      mie_n  = mpie_q;
      mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  assign epc_o        = mepc_q;
  assign irq_enable_o = mie_q;

  ////////////////////////////////////////////////////////////
  // controller contract
  ////////////////////////////////////////////////////////////

  a_ex_vs_branch: assert property (@(posedge clk) disable iff (!rst_n)
    !(exc_save_takenbranch_i && data_load_event_ex_i));

  a_save_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({exc_save_if_i, exc_save_id_i, exc_save_takenbranch_i}));

  a_trap_vs_mret: assert property (@(posedge clk) disable iff (!rst_n)
    !(save_exc_cause_i && exc_restore_mret_i));

endmodule

`default_nettype wire

//--- logic/csr_perf_counters.sv
// performance counters: event gating, counter registers, pcer and pcmr
`timescale 1ns/10ps
`default_nettype none

module csr_perf_counters
  import csr_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  csr_access_if.reg_blk acc,
  input  wire logic     id_valid_i,
  input  wire logic     is_decoding_i,
  input  wire logic     ld_stall_i,
  input  wire logic     imiss_i,
  input  wire logic     pc_set_i,
  input  wire logic     mem_load_i,
  input  wire logic     mem_store_i,
  input  wire logic     branch_i,
  input  wire logic     branch_taken_i
);

  logic       id_valid_q;
  perf_mask_t ev;
  perf_mask_t inc, inc_q;
  perf_mask_t pcer_q;
  logic [1:0] pcmr_q;
  perf_mask_t cnt_wr;
  csr_data_t  pccr_q [N_PERF_CNT];

  ////////////////////////////////////////////////////////////
  // events
  ////////////////////////////////////////////////////////////

  // stall events use last cycle's id_valid
  assign ev[EV_CYCLE]    = 1'b1;
  assign ev[EV_INSTR]    = id_valid_i & is_decoding_i;
  assign ev[EV_LD_STALL] = ld_stall_i & id_valid_q;
  // fetch wait, not counting redirects
  assign ev[EV_IMISS]    = imiss_i & ~pc_set_i;
  assign ev[EV_LOAD]     = mem_load_i;
  assign ev[EV_STORE]    = mem_store_i;
  assign ev[EV_BRANCH]   = branch_i & id_valid_q;
  assign ev[EV_BR_TAKEN] = branch_i & branch_taken_i & id_valid_q;

  // per-counter enable and global enable
  assign inc = ev & pcer_q & {N_PERF_CNT{pcmr_q[0]}};

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  // the all-counter address is write only, reads 0
  always_comb begin
    acc.rdata_perf = '0;
    acc.hit_perf   = 1'b0;
    if (acc.addr == ADDR_PCER) begin
      acc.hit_perf                   = 1'b1;
      acc.rdata_perf[N_PERF_CNT-1:0] = pcer_q;
    end else if (acc.addr == ADDR_PCMR) begin
      acc.hit_perf        = 1'b1;
      acc.rdata_perf[1:0] = pcmr_q;
    end else if (acc.addr == ADDR_PCCR_ALL) begin
      acc.hit_perf = 1'b1;
    end
    for (int i = 0; i < N_PERF_CNT; i++) begin
      if (acc.addr == ADDR_PCCR_BASE + csr_addr_t'(i)) begin
        acc.hit_perf   = 1'b1;
        acc.rdata_perf = pccr_q[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N_PERF_CNT; i++) begin
      cnt_wr[i] = acc.we && ((acc.addr == ADDR_PCCR_BASE + csr_addr_t'(i)) ||
                             (acc.addr == ADDR_PCCR_ALL));
    end
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= PCMR_RESET;
      for (int i = 0; i < N_PERF_CNT; i++) begin
        pccr_q[i] <= '0;
      end
    end else begin
      id_valid_q <= id_valid_i;
      // increment lands one cycle after the event
      inc_q      <= inc;
      if (acc.we && acc.addr == ADDR_PCER) begin
        pcer_q <= acc.wdata[N_PERF_CNT-1:0];
      end
      if (acc.we && acc.addr == ADDR_PCMR) begin
        pcmr_q <= acc.wdata[1:0];
      end
      for (int i = 0; i < N_PERF_CNT; i++) begin
        // csr write beats a pending increment
        if (cnt_wr[i]) begin
          pccr_q[i] <= acc.wdata;
        end else if (inc_q[i] && (pccr_q[i] != '1 || !pcmr_q[1])) begin
          pccr_q[i] <= pccr_q[i] + 32'd1;
        end
      end
    end
  end

  // saturated counter holds under a registered increment
  for (genvar g = 0; g < N_PERF_CNT; g++) begin : g_sat_chk
    a_sat_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (inc_q[g] && pcmr_q[1] && pccr_q[g] == '1 && !cnt_wr[g]) |=> (pccr_q[g] == '1));
  end

endmodule

`default_nettype wire

//--- logic/csr_file.sv
// csr file top level: access controller, trap registers and performance counters
`timescale 1ns/10ps
`default_nettype none

module csr_file
  import csr_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  // access port from decode
  input  wire logic        csr_access_i,
  input  wire csr_addr_t   csr_addr_i,
  input  wire csr_op_e     csr_op_i,
  input  wire csr_data_t   csr_wdata_i,
  // identity and boot
  input  wire logic [3:0]  core_id_i,
  input  wire logic [5:0]  cluster_id_i,
  input  wire logic [23:0] boot_addr_i,
  // trap entry and return
  input  wire csr_data_t   pc_if_i,
  input  wire csr_data_t   pc_id_i,
  input  wire csr_data_t   pc_ex_i,
  input  wire csr_data_t   branch_target_i,
  input  wire logic        exc_save_if_i,
  input  wire logic        exc_save_id_i,
  input  wire logic        exc_save_takenbranch_i,
  input  wire logic        data_load_event_ex_i,
  input  wire logic        save_exc_cause_i,
  input  wire exc_cause_t  exc_cause_i,
  input  wire logic        exc_restore_mret_i,
  // counter events
  input  wire logic        id_valid_i,
  input  wire logic        is_decoding_i,
  input  wire logic        ld_stall_i,
  input  wire logic        imiss_i,
  input  wire logic        pc_set_i,
  input  wire logic        mem_load_i,
  input  wire logic        mem_store_i,
  input  wire logic        branch_i,
  input  wire logic        branch_taken_i,
  output csr_data_t        csr_rdata_o,
  output csr_data_t        epc_o,
  output logic             irq_enable_o
);

  csr_access_if acc_if ();

  csr_access_ctrl i_csr_access_ctrl (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .acc          (acc_if.ctrl),
    .csr_rdata_o  (csr_rdata_o)
  );

  csr_trap_regs i_csr_trap_regs (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .acc                    (acc_if.reg_blk),
    .core_id_i              (core_id_i),
    .cluster_id_i           (cluster_id_i),
    .boot_addr_i            (boot_addr_i),
    .pc_if_i                (pc_if_i),
    .pc_id_i                (pc_id_i),
    .pc_ex_i                (pc_ex_i),
    .branch_target_i        (branch_target_i),
    .exc_save_if_i          (exc_save_if_i),
    .exc_save_id_i          (exc_save_id_i),
    .exc_save_takenbranch_i (exc_save_takenbranch_i),
    .data_load_event_ex_i   (data_load_event_ex_i),
    .save_exc_cause_i       (save_exc_cause_i),
    .exc_cause_i            (exc_cause_i),
    .exc_restore_mret_i     (exc_restore_mret_i),
    .epc_o                  (epc_o),
    .irq_enable_o           (irq_enable_o)
  );

  csr_perf_counters i_csr_perf_counters (
    .clk            (clk),
    .rst_n          (rst_n),
    .acc            (acc_if.reg_blk),
    .id_valid_i     (id_valid_i),
    .is_decoding_i  (is_decoding_i),
    .ld_stall_i     (ld_stall_i),
    .imiss_i        (imiss_i),
    .pc_set_i       (pc_set_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i)
  );

endmodule

`default_nettype wire

//--- dv/csr_tb_model.svh
// reference read function, lfsr random source and value compare task
`ifndef CSR_TB_MODEL_SVH
`define CSR_TB_MODEL_SVH

// expected csr_rdata_o for any address, built from the shadow state
function automatic csr_data_t ref_read(csr_addr_t addr);
  csr_data_t v;
  int        i;
  v = '0;
  case (addr)
    ADDR_MSTATUS: begin
      // machine mode only
      v[MSTATUS_MPP_LSB +: 2] = 2'b11;
      v[MSTATUS_MPIE_BIT]     = sh_mpie;
      v[MSTATUS_MIE_BIT]      = sh_mie;
    end
    ADDR_MTVEC:   v = csr_data_t'(BOOT_ADDR) << 8;
    ADDR_MEPC:    v = sh_mepc;
    ADDR_MCAUSE: begin
      v[31]  = sh_mcause[5];
      v[4:0] = sh_mcause[4:0];
    end
    ADDR_MHARTID: v = (csr_data_t'(CLUSTER_ID) << 5) | csr_data_t'(CORE_ID);
    ADDR_PCER:    v[N_PERF_CNT-1:0] = sh_pcer;
    ADDR_PCMR:    v[1:0] = sh_pcmr;
    default: begin
      // counter window, everything else reads zero
      for (i = 0; i < N_PERF_CNT; i++) begin
        if (addr == ADDR_PCCR_BASE + csr_addr_t'(i)) begin
          v = sh_cnt[i];
        end
      end
    end
  endcase
  return v;
endfunction

// 16 bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one lfsr step per bit taken
function automatic csr_data_t rand_bits(int n);
  csr_data_t v;
  int        i;
  v = '0;
  for (i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

task automatic check_val(string name, csr_data_t got, csr_data_t exp);
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t %s got 0x%08h exp 0x%08h", $time, name, got, exp);
    $display("Test FAILED");
    $fatal(1, "%s mismatch", name);
  end
endtask

`endif

//--- dv/tb_csr_file.sv
// testbench for the csr file: clock, reset, shadow model, stimulus and checking
`timescale 1ns/10ps
`default_nettype none

module tb_csr_file
  import csr_pkg::*;
();

  localparam logic [3:0]  CORE_ID    = 4'hA;
  localparam logic [5:0]  CLUSTER_ID = 6'h2B;
  localparam logic [23:0] BOOT_ADDR  = 24'h1C0008;
  localparam int          RST_CYCLES = 16;

  logic       clk;
  logic       rst_n;
  logic       csr_access;
  csr_addr_t  csr_addr;
  csr_op_e    csr_op;
  csr_data_t  csr_wdata;
  csr_data_t  pc_if;
  csr_data_t  pc_id;
  csr_data_t  pc_ex;
  csr_data_t  branch_target;
  logic       exc_save_if;
  logic       exc_save_id;
  logic       exc_save_takenbranch;
  logic       data_load_event_ex;
  logic       save_exc_cause;
  exc_cause_t exc_cause;
  logic       exc_restore_mret;
  logic       id_valid;
  logic       is_decoding;
  logic       ld_stall;
  logic       imiss;
  logic       pc_set;
  logic       mem_load;
  logic       mem_store;
  logic       branch;
  logic       branch_taken;
  csr_data_t  csr_rdata;
  csr_data_t  epc;
  logic       irq_enable;

  // shadow of the architectural state
  logic       sh_mie;
  logic       sh_mpie;
  csr_data_t  sh_mepc;
  exc_cause_t sh_mcause;
  perf_mask_t sh_pcer;
  logic [1:0] sh_pcmr;
  csr_data_t  sh_cnt [N_PERF_CNT];

  // expectations latched on the falling edge
  csr_data_t   exp_rdata;
  csr_data_t   exp_epc;
  logic        exp_irq;
  logic        chk_on;
  int          err_cnt;
  logic [15:0] lfsr_state;

  `include "csr_tb_model.svh"

  csr_file i_csr_file (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .csr_access_i           (csr_access),
    .csr_addr_i             (csr_addr),
    .csr_op_i               (csr_op),
    .csr_wdata_i            (csr_wdata),
    .core_id_i              (CORE_ID),
    .cluster_id_i           (CLUSTER_ID),
    .boot_addr_i            (BOOT_ADDR),
    .pc_if_i                (pc_if),
    .pc_id_i                (pc_id),
    .pc_ex_i                (pc_ex),
    .branch_target_i        (branch_target),
    .exc_save_if_i          (exc_save_if),
    .exc_save_id_i          (exc_save_id),
    .exc_save_takenbranch_i (exc_save_takenbranch),
    .data_load_event_ex_i   (data_load_event_ex),
    .save_exc_cause_i       (save_exc_cause),
    .exc_cause_i            (exc_cause),
    .exc_restore_mret_i     (exc_restore_mret),
    .id_valid_i             (id_valid),
    .is_decoding_i          (is_decoding),
    .ld_stall_i             (ld_stall),
    .imiss_i                (imiss),
    .pc_set_i               (pc_set),
    .mem_load_i             (mem_load),
    .mem_store_i            (mem_store),
    .branch_i               (branch),
    .branch_taken_i         (branch_taken),
    .csr_rdata_o            (csr_rdata),
    .epc_o                  (epc),
    .irq_enable_o           (irq_enable)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // outputs are stable before the rising edge
  always @(posedge clk) begin
    if (chk_on) begin
      check_val("csr_rdata_o", csr_rdata, exp_rdata);
      check_val("epc_o", epc, exp_epc);
      check_val("irq_enable_o", {31'b0, irq_enable}, {31'b0, exp_irq});
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic set_idle();
    csr_access           = 1'b0;
    csr_addr             = ADDR_MEPC;
    csr_op               = CSR_OP_NONE;
    csr_wdata            = '0;
    exc_save_if          = 1'b0;
    exc_save_id          = 1'b0;
    exc_save_takenbranch = 1'b0;
    data_load_event_ex   = 1'b0;
    save_exc_cause       = 1'b0;
    exc_cause            = '0;
    exc_restore_mret     = 1'b0;
    mem_load             = 1'b0;
    mem_store            = 1'b0;
  endtask

  task automatic write_shadow(csr_addr_t addr, csr_data_t v);
    int i;
    case (addr)
      ADDR_MSTATUS: begin
        sh_mie  = v[MSTATUS_MIE_BIT];
        sh_mpie = v[MSTATUS_MPIE_BIT];
      end
      ADDR_MEPC:   sh_mepc   = v;
      ADDR_MCAUSE: sh_mcause = {v[31], v[4:0]};
      ADDR_PCER:   sh_pcer   = v[N_PERF_CNT-1:0];
      ADDR_PCMR:   sh_pcmr   = v[1:0];
      default: begin
        for (i = 0; i < N_PERF_CNT; i++) begin
          if (addr == ADDR_PCCR_ALL || addr == ADDR_PCCR_BASE + csr_addr_t'(i)) begin
            sh_cnt[i] = v;
          end
        end
      end
    endcase
  endtask

  // one clock cycle: inputs already set on the falling edge
  task automatic run_cycle();
    logic       old_mie;
    logic       old_mpie;
    perf_mask_t inc;
    csr_data_t  nv;
    int         i;
    exp_rdata = ref_read(csr_addr);
    exp_epc   = sh_mepc;
    exp_irq   = sh_mie;
    chk_on    = 1'b1;
    @(posedge clk);
    old_mie  = sh_mie;
    old_mpie = sh_mpie;
    // gating uses the enables of the event cycle
    inc = '0;
    inc[EV_CYCLE] = 1'b1;
    inc[EV_LOAD]  = mem_load;
    inc[EV_STORE] = mem_store;
    inc = inc & sh_pcer & {N_PERF_CNT{sh_pcmr[0]}};
    if (csr_access && csr_op != CSR_OP_NONE) begin
      case (csr_op)
        CSR_OP_SET:   nv = exp_rdata | csr_wdata;
        CSR_OP_CLEAR: nv = exp_rdata & ~csr_wdata;
        default:      nv = csr_wdata;
      endcase
      write_shadow(csr_addr, nv);
    end
    if (save_exc_cause) begin
      if (data_load_event_ex) begin
        sh_mepc = pc_ex;
      end else if (exc_save_if) begin
        sh_mepc = pc_if;
      end else if (exc_save_takenbranch) begin
        sh_mepc = branch_target;
      end else begin
        sh_mepc = pc_id;
      end
      sh_mcause = exc_cause;
      sh_mpie   = old_mie;
      sh_mie    = 1'b0;
    end else if (exc_restore_mret) begin
      sh_mie  = old_mpie;
      sh_mpie = 1'b1;
    end
    // the real increment lands one edge later, reads happen after idling
    for (i = 0; i < N_PERF_CNT; i++) begin
      if (inc[i] && (sh_cnt[i] != '1 || !sh_pcmr[1])) begin
        sh_cnt[i] = sh_cnt[i] + 32'd1;
      end
    end
    @(negedge clk);
  endtask

  task automatic csr_cycle(csr_op_e op, csr_addr_t addr, csr_data_t data);
    csr_access = 1'b1;
    csr_addr   = addr;
    csr_op     = op;
    csr_wdata  = data;
    run_cycle();
    set_idle();
  endtask

  task automatic wait_irq(logic level, int limit);
    int n;
    n = 0;
    while (irq_enable !== level && n < limit) begin
      run_cycle();
      n++;
    end
    if (irq_enable !== level) begin
      $display("irq_enable_o never reached %0b within %0d cycles", level, limit);
      $display("Test FAILED");
      $fatal(1, "irq wait timeout");
    end
  endtask

  // random load and store pulses, then two idle cycles for the delayed increment
  task automatic pulse_events(int cycles);
    int k;
    for (k = 0; k < cycles; k++) begin
      mem_load  = rand_bits(1);
      mem_store = rand_bits(1);
      run_cycle();
    end
    set_idle();
    run_cycle();
    run_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int        k;
    int        src;
    csr_addr_t addr;
    lfsr_state = 16'd35;
    err_cnt    = 0;
    chk_on     = 1'b0;
    rst_n      = 1'b0;
    pc_if = '0;
    pc_id = '0;
    pc_ex = '0;
    branch_target = '0;
    id_valid     = 1'b0;
    is_decoding  = 1'b0;
    ld_stall     = 1'b0;
    imiss        = 1'b0;
    pc_set       = 1'b0;
    branch       = 1'b0;
    branch_taken = 1'b0;
    set_idle();
    sh_mie    = 1'b0;
    sh_mpie   = 1'b0;
    sh_mepc   = '0;
    sh_mcause = '0;
    sh_pcer   = '0;
    sh_pcmr   = PCMR_RESET;
    for (k = 0; k < N_PERF_CNT; k++) begin
      sh_cnt[k] = '0;
    end
    for (k = 0; k < RST_CYCLES; k++) begin
      @(negedge clk);
    end
    rst_n = 1'b1;

    // reset and identity values
    csr_cycle(CSR_OP_NONE, ADDR_MSTATUS, '0);
    csr_cycle(CSR_OP_NONE, ADDR_PCMR, '0);
    csr_cycle(CSR_OP_NONE, ADDR_MHARTID, '0);
    csr_cycle(CSR_OP_NONE, ADDR_MTVEC, '0);
    csr_cycle(CSR_OP_NONE, ADDR_MISA, '0);
    csr_cycle(CSR_OP_NONE, ADDR_MVENDORID, '0);
    csr_cycle(CSR_OP_NONE, ADDR_MARCHID, '0);
    csr_cycle(CSR_OP_NONE, ADDR_MIMPID, '0);
    csr_cycle(CSR_OP_NONE, 12'h123, '0);

    // random write, set, clear, each read back next cycle
    for (k = 0; k < 60; k++) begin
      src  = rand_bits(2) % 3;
      addr = (src == 0) ? ADDR_MSTATUS : (src == 1) ? ADDR_MEPC : ADDR_MCAUSE;
      csr_cycle(csr_op_e'(rand_bits(2)), addr, rand_bits(32));
      csr_cycle(CSR_OP_NONE, addr, '0);
    end

    // trap entry from every pc source, a same-cycle mepc write loses
    for (src = 0; src < 5; src++) begin
      csr_cycle(CSR_OP_WRITE, ADDR_MSTATUS, rand_bits(32));
      pc_if         = 32'h1000_0000 | rand_bits(24);
      pc_id         = 32'h2000_0000 | rand_bits(24);
      pc_ex         = 32'h3000_0000 | rand_bits(24);
      branch_target = 32'h4000_0000 | rand_bits(24);
      exc_cause            = exc_cause_t'(rand_bits(6));
      save_exc_cause       = 1'b1;
      exc_save_if          = (src == 0);
      exc_save_id          = (src == 1) || (src == 3);
      exc_save_takenbranch = (src == 2);
      data_load_event_ex   = (src == 3);
      csr_access = 1'b1;
      csr_addr   = ADDR_MEPC;
      csr_op     = CSR_OP_WRITE;
      csr_wdata  = rand_bits(32);
      run_cycle();
      set_idle();
      csr_cycle(CSR_OP_NONE, ADDR_MEPC, '0);
      csr_cycle(CSR_OP_NONE, ADDR_MCAUSE, '0);
      csr_cycle(CSR_OP_NONE, ADDR_MSTATUS, '0);
    end

    // mret restores mie from mpie, both polarities
    for (k = 0; k < 2; k++) begin
      csr_cycle(CSR_OP_WRITE, ADDR_MSTATUS, k[0] ? 32'h8 : 32'h0);
      save_exc_cause = 1'b1;
      exc_cause      = exc_cause_t'(rand_bits(6));
      run_cycle();
      set_idle();
      exc_restore_mret = 1'b1;
      run_cycle();
      set_idle();
      wait_irq(k[0], 4);
      csr_cycle(CSR_OP_NONE, ADDR_MSTATUS, '0);
    end

    ////////////////////////////////////////////////////////////
    // performance counters
    ////////////////////////////////////////////////////////////

    csr_cycle(CSR_OP_WRITE, ADDR_PCMR, 32'd3);
    csr_cycle(CSR_OP_WRITE, ADDR_PCER, (32'd1 << EV_LOAD) | (32'd1 << EV_STORE));
    csr_cycle(CSR_OP_WRITE, ADDR_PCCR_ALL, '0);
    pulse_events(48);
    csr_cycle(CSR_OP_NONE, ADDR_PCCR_BASE + csr_addr_t'(EV_LOAD), '0);
    csr_cycle(CSR_OP_NONE, ADDR_PCCR_BASE + csr_addr_t'(EV_STORE), '0);
    csr_cycle(CSR_OP_NONE, ADDR_PCER, '0);
    // global enable off, counters must hold
    csr_cycle(CSR_OP_WRITE, ADDR_PCMR, 32'd2);
    pulse_events(16);
    csr_cycle(CSR_OP_NONE, ADDR_PCCR_BASE + csr_addr_t'(EV_LOAD), '0);
    csr_cycle(CSR_OP_NONE, ADDR_PCCR_BASE + csr_addr_t'(EV_STORE), '0);

    // saturation, then wrap with saturation off
    csr_cycle(CSR_OP_WRITE, ADDR_PCER, 32'd1 << EV_LOAD);
    csr_cycle(CSR_OP_WRITE, ADDR_PCMR, 32'd3);
    csr_cycle(CSR_OP_WRITE, ADDR_PCCR_ALL, '1);
    mem_load = 1'b1;
    for (k = 0; k < 4; k++) begin
      run_cycle();
    end
    set_idle();
    run_cycle();
    run_cycle();
    csr_cycle(CSR_OP_NONE, ADDR_PCCR_BASE + csr_addr_t'(EV_LOAD), '0);
    csr_cycle(CSR_OP_WRITE, ADDR_PCMR, 32'd1);
    // store event too, its counter is disabled
    mem_load  = 1'b1;
    mem_store = 1'b1;
    run_cycle();
    set_idle();
    run_cycle();
    run_cycle();
    csr_cycle(CSR_OP_NONE, ADDR_PCCR_BASE + csr_addr_t'(EV_LOAD), '0);
    csr_cycle(CSR_OP_NONE, ADDR_PCCR_BASE + csr_addr_t'(EV_STORE), '0);
    csr_cycle(CSR_OP_NONE, ADDR_PCCR_BASE + csr_addr_t'(EV_CYCLE), '0);
    csr_cycle(CSR_OP_NONE, ADDR_PCCR_ALL, '0);

    chk_on = 1'b0;
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+dv
logic/csr_pkg.sv
logic/csr_access_if.sv
logic/csr_access_ctrl.sv
logic/csr_trap_regs.sv
logic/csr_perf_counters.sv
logic/csr_file.sv
dv/tb_csr_file.sv

//--- Bender.yml
package:
  name: csr_file

sources:
  - files:
      - logic/csr_pkg.sv
      - logic/csr_access_if.sv
      - logic/csr_access_ctrl.sv
      - logic/csr_trap_regs.sv
      - logic/csr_perf_counters.sv
      - logic/csr_file.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_csr_file.sv
